// File: hw/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module alu (
  input  logic              clk,     // Core clock
  input  logic              rst_n,   // Async reset, active low
  input  logic              start,   // Operands valid this cycle
  input  proc_pkg::alu_op_t op,      // Function select
  input  proc_pkg::word_t   a,       // First operand
  input  proc_pkg::word_t   b,       // Second operand or shift amount
  output logic              busy,    // Shift in progress
  output logic              done,    // Result valid this cycle
  output proc_pkg::word_t   result   // Function output
);

  import proc_pkg::*;

  localparam int W    = `PROC_WORD_W;
  localparam int H    = W / 2;        // Byte boundary for LLB and LHB
  localparam int SH_W = $clog2(W);    // Shift amount width

  logic [SH_W-1:0] shamt;     // Requested shift distance
  logic [SH_W-1:0] cnt;       // Steps still to go
  logic            is_shift;
  word_t           sum;
  word_t           diff;
  logic            add_ovf;   // Signed overflow on add
  logic            sub_ovf;   // Signed overflow on subtract
  word_t           sat_val;   // Clamp value chosen by sign of a
  word_t           comb_res;  // Single-cycle result
  word_t           sh_q;      // Shift register
  alu_op_t         op_q;      // Shift kind held during the run

  // One bit of movement per call
  function automatic word_t shift_step(input alu_op_t f, input word_t v);
    case (f)
      ALU_SLL: shift_step = {v[W-2:0], 1'b0};
      ALU_SRA: shift_step = {v[W-1], v[W-1:1]};  // Sign fills from the top
      default: shift_step = {v[0], v[W-1:1]};    // Rotate right
    endcase
  endfunction

  assign shamt    = b[SH_W-1:0];
  assign is_shift = (op == ALU_SLL) || (op == ALU_SRA) || (op == ALU_ROR);

  //////////////////////////////////////////////////
  // Single-cycle datapath
  //////////////////////////////////////////////////
  assign sum     = a + b;
  assign diff    = a - b;
  assign add_ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
  assign sub_ovf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
  assign sat_val = a[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};

  always_comb begin
    case (op)
      ALU_ADD: comb_res = add_ovf ? sat_val : sum;
      ALU_SUB: comb_res = sub_ovf ? sat_val : diff;
      ALU_XOR: comb_res = a ^ b;
      ALU_LLB: comb_res = {a[W-1:H], b[H-1:0]};  // Keep high byte
      ALU_LHB: comb_res = {b[H-1:0], a[H-1:0]};  // Keep low byte
      default: comb_res = a;                     // Shift by zero
    endcase
  end

  //////////////////////////////////////////////////
  // Iterative shifter
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (start && is_shift && (shamt != '0)) begin
      cnt <= shamt;                 // Load distance
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;            // One step per cycle
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sh_q <= a;
      op_q <= op;
    end else if (cnt != '0) begin
      sh_q <= shift_step(op_q, sh_q);
    end
  end

  assign busy   = (cnt != '0);
  assign done   = (start && !(is_shift && (shamt != '0))) || (cnt == SH_W'(1));
  assign result = busy ? shift_step(op_q, sh_q) : comb_res;  // Last step is combinational

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
  input  logic                  clk,           // Core clock
  input  logic                  rst_n,         // Async reset, active low
  input  logic                  empty,         // Queue has nothing to issue
  input  proc_pkg::ibuf_entry_t pop_entry,     // Head of the queue
  output logic                  pop,           // Take the head entry
  output logic                  halted,        // HLT has been executed
  output logic                  retire_valid,  // A register write completed
  output proc_pkg::reg_idx_t    retire_rd,     // Register written
  output proc_pkg::word_t       retire_data    // Value written
);

  import proc_pkg::*;

  instr_t   instr;       // Field view of the head word
  alu_op_t  alu_op;
  logic     is_alu;      // Opcode goes through the ALU
  logic     byte_ld;     // LLB or LHB
  logic     imm_shift;   // SLL, SRA or ROR
  reg_idx_t rs_idx;
  word_t    rs_data;
  word_t    rt_data;
  word_t    alu_b;
  logic     alu_start;
  logic     alu_busy;
  logic     alu_done;
  word_t    alu_result;
  reg_idx_t rd_q;        // Destination of a running shift
  logic     pcs_wr;      // PCS write this cycle
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  assign instr = instr_t'(pop_entry.instr);
  assign pop   = !empty && !alu_busy && !halted;  // Idle means no shift running

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  always_comb begin
    is_alu    = 1'b1;
    byte_ld   = 1'b0;
    imm_shift = 1'b0;
    alu_op    = ALU_ADD;
    case (instr.opcode)
      OP_ADD:  alu_op = ALU_ADD;
      OP_SUB:  alu_op = ALU_SUB;
      OP_XOR:  alu_op = ALU_XOR;
      OP_SLL:  begin alu_op = ALU_SLL; imm_shift = 1'b1; end
      OP_SRA:  begin alu_op = ALU_SRA; imm_shift = 1'b1; end
      OP_ROR:  begin alu_op = ALU_ROR; imm_shift = 1'b1; end
      OP_LLB:  begin alu_op = ALU_LLB; byte_ld = 1'b1; end
      OP_LHB:  begin alu_op = ALU_LHB; byte_ld = 1'b1; end
      default: is_alu = 1'b0;   // PCS, HLT and unsupported codes
    endcase
  end

  assign rs_idx = byte_ld ? instr.rd : instr.rs;  // Byte loads merge into rd

  always_comb begin
    if (byte_ld) begin
      alu_b = word_t'(pop_entry.instr[7:0]);   // imm8
    end else if (imm_shift) begin
      alu_b = word_t'(instr.rt);               // imm4 shift amount
    end else begin
      alu_b = rt_data;
    end
  end

  assign alu_start = pop && is_alu;
  assign pcs_wr    = pop && (instr.opcode == OP_PCS);

  reg_file i_rf (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_idx  (rs_idx),
    .rt_idx  (instr.rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

  alu i_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (alu_start),
    .op     (alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .busy   (alu_busy),
    .done   (alu_done),
    .result (alu_result)
  );

  //////////////////////////////////////////////////
  // Write-back and halt
  //////////////////////////////////////////////////
  assign wr_en   = alu_done || pcs_wr;
  assign wr_idx  = alu_busy ? rd_q : instr.rd;            // Shift finishing uses latched rd
  assign wr_data = pcs_wr ? pop_entry.next_pc : alu_result;

  always_ff @(posedge clk) begin
    if (alu_start) begin
      rd_q <= instr.rd;
    end
    if (wr_en) begin
      retire_rd   <= wr_idx;
      retire_data <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      retire_valid <= wr_en;
      if (pop && (instr.opcode == OP_HLT)) begin
        halted <= 1'b1;             // Held until reset
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module fetch_unit (
  input  logic                  clk,             // Core clock
  input  logic                  rst_n,           // Async reset, active low
  input  logic                  halted,          // Core has executed HLT
  input  logic                  full,            // Queue has no free slot
  input  logic                  mem_data_valid,  // Read data strobe
  input  proc_pkg::word_t       mem_data_in,     // Returned instruction word
  output logic                  mem_en,          // One-cycle read request
  output proc_pkg::word_t       mem_addr,        // Read address
  output proc_pkg::word_t       pc,              // Address of next fetch
  output logic                  push,            // Queue write strobe
  output proc_pkg::ibuf_entry_t push_entry       // Instruction plus next address
);

  import proc_pkg::*;

  //////////////////////////////////////////////////
  // Internal state
  //////////////////////////////////////////////////
  logic  run;      // Set on the first edge out of reset
  logic  waiting;  // One read is outstanding
  word_t pc_q;     // Program counter
  word_t next_pc;  // Address after the one being fetched

  assign next_pc = pc_q + word_t'(`PROC_PC_STEP);

  // New request only with no read in flight and room guaranteed in the queue
  assign mem_en   = run && !waiting && !full && !halted;
  assign mem_addr = pc_q;
  assign pc       = pc_q;

  // Response goes straight into the queue
  assign push               = mem_data_valid;
  assign push_entry.instr   = mem_data_in;
  assign push_entry.next_pc = next_pc;

  //////////////////////////////////////////////////
  // Request tracking and PC update
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run     <= 1'b0;
      waiting <= 1'b0;
      pc_q    <= word_t'(`PROC_RESET_PC);
    end else begin
      run <= 1'b1;                  // Stays set until next reset
      if (mem_en) begin
        waiting <= 1'b1;            // Request launched
      end else if (mem_data_valid) begin
        waiting <= 1'b0;            // Memory answered
      end
      if (mem_data_valid) begin
        pc_q <= next_pc;            // Step past the fetched word
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/instr_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module instr_queue (
  input  logic                  clk,         // Core clock
  input  logic                  rst_n,       // Async reset, active low
  input  logic                  push,        // Write strobe from fetch
  input  proc_pkg::ibuf_entry_t push_entry,  // Entry to store
  input  logic                  pop,         // Read strobe from execute
  output proc_pkg::ibuf_entry_t pop_entry,   // Head entry
  output logic                  full,        // No free slot
  output logic                  empty        // No valid entry
);

  import proc_pkg::*;

  localparam int DEPTH = `PROC_IBUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);  // Wrap point

  ibuf_entry_t      mem [DEPTH];  // Entry storage
  logic [PTR_W-1:0] wr_ptr;       // Next slot to fill
  logic [PTR_W-1:0] rd_ptr;       // Current head
  logic [CNT_W-1:0] count;        // Valid entries
  logic             do_push;
  logic             do_pop;

  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign pop_entry = mem[rd_ptr];  // Head is valid while empty is low

  assign do_push = push && !full;   // Overflow is dropped
  assign do_pop  = pop && !empty;   // Underflow is ignored

  //////////////////////////////////////////////////
  // Storage write
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;  // Fill only
        2'b01:   count <= count - 1'b1;  // Drain only
        default: count <= count;         // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/proc_pkg.sv
`include "proc_defs.svh"

package proc_pkg;

  typedef logic [`PROC_WORD_W-1:0]            word_t;     // Data or instruction word
  typedef logic [$clog2(`PROC_REG_COUNT)-1:0] reg_idx_t;  // Register number

  // Opcode field encodings in bits 15 to 12
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,   // Saturating add
    OP_SUB = 4'd1,   // Saturating subtract
    OP_XOR = 4'd2,
    OP_SLL = 4'd4,   // Shift left logical by imm4
    OP_SRA = 4'd5,   // Shift right arithmetic by imm4
    OP_ROR = 4'd6,   // Rotate right by imm4
    OP_LLB = 4'd10,  // Load low byte
    OP_LHB = 4'd11,  // Load high byte
    OP_PCS = 4'd14,  // Write next-instruction address
    OP_HLT = 4'd15   // Stop the core
  } opcode_t;

  // Functions the ALU knows about
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_SLL,
    ALU_SRA,
    ALU_ROR,
    ALU_LLB,
    ALU_LHB
  } alu_op_t;

  // Field view of an instruction word
  typedef struct packed {
    opcode_t  opcode;  // Bits 15 to 12
    reg_idx_t rd;      // Destination
    reg_idx_t rs;      // First source or upper nibble of imm8
    reg_idx_t rt;      // Second source, shift amount or lower nibble of imm8
  } instr_t;

  // One instruction queue slot
  typedef struct packed {
    word_t instr;    // Raw instruction word
    word_t next_pc;  // Address of the following instruction
  } ibuf_entry_t;

endpackage

// File: hw/proc_top.sv
`timescale 1ns/100ps
`default_nettype none

module proc_top (
  input  logic               clk,             // Core clock
  input  logic               rst_n,           // Async reset, active low
  input  logic               mem_data_valid,  // Read data strobe
  input  proc_pkg::word_t    mem_data_in,     // Read data
  output logic               mem_en,          // Read request pulse
  output proc_pkg::word_t    mem_addr,        // Read address
  output logic               hlt,             // Core halted
  output proc_pkg::word_t    pc,              // Program counter
  output logic               retire_valid,    // Write-back strobe
  output proc_pkg::reg_idx_t retire_rd,       // Written register
  output proc_pkg::word_t    retire_data      // Written value
);

  import proc_pkg::*;

  //////////////////////////////////////////////////
  // Fetch to queue to execute wiring
  //////////////////////////////////////////////////
  logic        push;        // Fetch writes an entry
  ibuf_entry_t push_entry;
  logic        pop;         // Execute takes the head
  ibuf_entry_t pop_entry;
  logic        full;        // Back-pressure to fetch
  logic        empty;       // Nothing for execute

  fetch_unit i_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .halted         (hlt),          // Stops new requests
    .full           (full),
    .mem_data_valid (mem_data_valid),
    .mem_data_in    (mem_data_in),
    .mem_en         (mem_en),
    .mem_addr       (mem_addr),
    .pc             (pc),
    .push           (push),
    .push_entry     (push_entry)
  );

  instr_queue i_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .pop_entry  (pop_entry),
    .full       (full),
    .empty      (empty)
  );

  exec_unit i_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .empty        (empty),
    .pop_entry    (pop_entry),
    .pop          (pop),
    .halted       (hlt),            // Also the top-level status
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module reg_file (
  input  logic               clk,      // Core clock
  input  logic               rst_n,    // Async reset, active low
  input  proc_pkg::reg_idx_t rs_idx,   // Read port A select
  input  proc_pkg::reg_idx_t rt_idx,   // Read port B select
  output proc_pkg::word_t    rs_data,  // Read port A data
  output proc_pkg::word_t    rt_data,  // Read port B data
  input  logic               wr_en,    // Write strobe
  input  proc_pkg::reg_idx_t wr_idx,   // Write select
  input  proc_pkg::word_t    wr_data   // Write data
);

  import proc_pkg::*;

  word_t regs [`PROC_REG_COUNT];  // Architectural state

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PROC_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;    // r0 is never written
    end
  end

  // Reads bypass nothing and r0 returns zero
  assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
  assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

// File: include/proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////
`define PROC_WORD_W     16  // Data and instruction width
`define PROC_REG_COUNT  16  // Architectural registers including r0
`define PROC_IBUF_DEPTH 4   // Instruction queue entries

//////////////////////////////////////////////////
// Fetch addressing
//////////////////////////////////////////////////
`define PROC_RESET_PC   0   // First fetch address
`define PROC_PC_STEP    2   // Byte step between instructions

`endif

// File: proc.f
+incdir+include
hw/proc_pkg.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/alu.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/proc_top.sv
verification/proc_tb_mem.sv
verification/proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the processor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module proc_tb -f proc.f --Mdir obj_dir -o proc_sim

# The run may stop on $fatal, so the verdict comes from its output
out=$(./obj_dir/proc_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^>>> PASS$'

// File: verification/proc_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "proc_defs.svh"

module proc_tb;

  import proc_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DLY   = 1;
  localparam int RESET_CYC   = 3;
  localparam int PROG_WORDS  = 64;
  localparam int MAX_LAT     = 5;
  localparam int WATCHDOG_NS = 40 * PROG_WORDS * MAX_LAT * CLK_PERIOD;
  localparam int DRAIN_CYC   = 2 * MAX_LAT + 2;  // Room for the last answer

  logic     clk;
  logic     rst_n;
  logic     mem_data_valid;
  word_t    mem_data_in;
  logic     mem_en;
  word_t    mem_addr;
  logic     hlt;
  word_t    pc;
  logic     retire_valid;
  reg_idx_t retire_rd;
  word_t    retire_data;

  word_t    ref_regs [`PROC_REG_COUNT];  // Reference register state
  reg_idx_t exp_rd   [PROG_WORDS];       // Expected retires in program order
  word_t    exp_data [PROG_WORDS];
  int       exp_cnt;
  int       retire_cnt;
  logic     model_halted;   // HLT seen in the fetch stream
  word_t    ref_pc;         // Address of the word being fetched or answered
  logic     outstanding;    // Request without answer yet
  logic     saw_full;
  logic     queue_full;

  assign queue_full = i_dut.i_queue.full;

  proc_top i_dut (.*);

  proc_tb_mem #(.WORDS(PROG_WORDS), .MAX_LAT(MAX_LAT)) i_mem (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Signed sum or difference clamped to 16 bits
  function automatic word_t clamp16(input int v);
    if (v > 32767) begin
      return 16'h7FFF;
    end
    if (v < -32768) begin
      return 16'h8000;
    end
    return word_t'(v);
  endfunction

  //////////////////////////////////////////////////
  // Reference model fed by the fetch stream
  //////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin : ref_model
    reg_idx_t    rd;
    word_t       a;
    word_t       b;
    word_t       val;
    logic [31:0] rot;
    logic        wr;
    if (!rst_n) begin
      for (int i = 0; i < `PROC_REG_COUNT; i++) begin
        ref_regs[i] = '0;
      end
      exp_cnt      <= 0;
      model_halted <= 1'b0;
    end else if (mem_data_valid && !model_halted) begin
      rd  = mem_data_in[11:8];
      a   = ref_regs[mem_data_in[7:4]];
      b   = ref_regs[mem_data_in[3:0]];
      rot = {a, a} >> mem_data_in[3:0];
      wr  = 1'b1;
      val = '0;
      case (mem_data_in[15:12])
        OP_ADD:  val = clamp16(int'($signed(a)) + int'($signed(b)));
        OP_SUB:  val = clamp16(int'($signed(a)) - int'($signed(b)));
        OP_XOR:  val = a ^ b;
        OP_SLL:  val = a << mem_data_in[3:0];
        OP_SRA:  val = word_t'($signed(a) >>> mem_data_in[3:0]);
        OP_ROR:  val = rot[15:0];
        OP_LLB:  val = {ref_regs[rd][15:8], mem_data_in[7:0]};
        OP_LHB:  val = {mem_data_in[7:0], ref_regs[rd][7:0]};
        OP_PCS:  val = ref_pc + word_t'(`PROC_PC_STEP);  // Own address plus one step
        OP_HLT: begin
          wr           = 1'b0;
          model_halted <= 1'b1;
        end
        default: wr = 1'b0;                              // Dropped opcodes
      endcase
      if (wr) begin
        if (rd != '0) begin
          ref_regs[rd] = val;
        end
        exp_rd[exp_cnt]   <= rd;
        exp_data[exp_cnt] <= val;
        exp_cnt           <= exp_cnt + 1;
      end
    end
  end

  // Bus bookkeeping
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_pc      <= word_t'(`PROC_RESET_PC);
      outstanding <= 1'b0;
      retire_cnt  <= 0;
      saw_full    <= 1'b0;
    end else begin
      if (mem_en) begin
        outstanding <= 1'b1;
      end else if (mem_data_valid) begin
        outstanding <= 1'b0;
      end
      if (mem_data_valid) begin
        ref_pc <= ref_pc + word_t'(`PROC_PC_STEP);  // One word per answer
      end
      if (retire_valid) begin
        retire_cnt <= retire_cnt + 1;
      end
      if (queue_full) begin
        saw_full <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  reset_idle: assert property (@(posedge clk)
      !rst_n |-> !mem_en && !hlt && !retire_valid && pc == word_t'(`PROC_RESET_PC))
    else stop_with_error($sformatf("Mismatch at %0t: core outputs active in reset", $time));

  fetch_order: assert property (@(posedge clk) disable iff (!rst_n)
      mem_en |-> mem_addr == ref_pc)
    else stop_with_error($sformatf("Mismatch at %0t: fetch address %h, expected %h",
                                   $time, $sampled(mem_addr), $sampled(ref_pc)));

  pc_track: assert property (@(posedge clk) disable iff (!rst_n)
      pc == ref_pc)
    else stop_with_error($sformatf("Mismatch at %0t: pc %h, expected %h",
                                   $time, $sampled(pc), $sampled(ref_pc)));

  one_request: assert property (@(posedge clk) disable iff (!rst_n)
      mem_en |-> !outstanding)
    else stop_with_error("A new read was issued while one was still outstanding");

  queue_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
      queue_full |-> !mem_en)
    else stop_with_error("A read was issued while the instruction queue was full");

  retire_known: assert property (@(posedge clk) disable iff (!rst_n)
      retire_valid |-> retire_cnt < exp_cnt)
    else stop_with_error("An instruction retired that the program does not allow");

  retire_value: assert property (@(posedge clk) disable iff (!rst_n)
      retire_valid && retire_cnt < exp_cnt |->
        retire_rd == exp_rd[retire_cnt] && retire_data == exp_data[retire_cnt])
    else stop_with_error($sformatf("Mismatch at %0t: retire r%0d=%h, expected r%0d=%h",
                                   $time, $sampled(retire_rd), $sampled(retire_data),
                                   exp_rd[$sampled(retire_cnt)],
                                   exp_data[$sampled(retire_cnt)]));

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      hlt |=> hlt)
    else stop_with_error($sformatf("Mismatch at %0t: hlt fell before reset", $time));

  halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      hlt |-> !retire_valid)
    else stop_with_error("An instruction retired after the core halted");

  halt_fetch: assert property (@(posedge clk) disable iff (!rst_n)
      hlt |-> !mem_en)
    else stop_with_error("A read was issued after the core halted");

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////
  initial begin : watchdog
    #WATCHDOG_NS;
    stop_with_error("Timeout: the core never reached its halt");
  end

  initial begin : main
    rst_n = 1'b1;
    #DRIVE_DLY;
    rst_n = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    wait (hlt === 1'b1);
    repeat (DRAIN_CYC) @(posedge clk);      // Late answer and quiet window
    if (retire_cnt != exp_cnt || exp_cnt == 0) begin
      stop_with_error($sformatf("Only %0d of %0d expected results retired",
                                retire_cnt, exp_cnt));
    end else if (!saw_full) begin
      stop_with_error("The instruction queue never filled, back-pressure untested");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/proc_tb_mem.sv
`timescale 1ns/100ps
`default_nettype none

module proc_tb_mem #(
  parameter int WORDS   = 64,  // Depth in instruction words
  parameter int MAX_LAT = 5    // Longest answer delay in cycles
) (
  input  logic            clk,             // Core clock
  input  logic            rst_n,           // Async reset, active low
  input  logic            mem_en,          // Read request from the core
  input  proc_pkg::word_t mem_addr,        // Byte address of the request
  output logic            mem_data_valid,  // One-cycle answer strobe
  output proc_pkg::word_t mem_data_in      // Instruction word
);

  import proc_pkg::*;

  localparam int AW        = $clog2(WORDS);  // Word index width
  localparam int DRIVE_DLY = 1;              // Drive point after the edge

  word_t  prog [WORDS];    // Program image
  int     n_words;         // Next free slot while loading
  integer seed = 32'h9e05; // Latency stream

  task automatic put(input word_t w);
    prog[n_words] = w;
    n_words = n_words + 1;
  endtask

  //////////////////////////////////////////////////
  // Program image
  //////////////////////////////////////////////////
  initial begin : load_program
    opcode_t sh;
    for (int i = 0; i < WORDS; i++) begin
      prog[i] = word_t'(32'hF000 | i);  // HLT filler tagged with its own index
    end
    n_words = 0;
    put({OP_LLB, 4'd1, 8'hFF});        // r1 = 0x00FF
    put({OP_LHB, 4'd1, 8'h7F});        // r1 = 0x7FFF
    put({OP_LLB, 4'd2, 8'h01});
    put({OP_LHB, 4'd2, 8'h00});        // r2 = 1
    put({OP_LLB, 4'd4, 8'h00});
    put({OP_LHB, 4'd4, 8'h80});        // r4 = 0x8000
    put({OP_ADD, 4'd3, 4'd1, 4'd2});   // Positive saturation
    put({OP_SUB, 4'd5, 4'd4, 4'd2});   // Negative saturation
    put({OP_ADD, 4'd3, 4'd4, 4'd4});   // Both negative, clamps low
    put({OP_XOR, 4'd6, 4'd1, 4'd4});
    put({OP_ADD, 4'd7, 4'd0, 4'd6});   // r0 as source
    put({OP_SUB, 4'd8, 4'd2, 4'd0});
    put({OP_PCS, 4'd9, 8'h00});
    put(16'h8123);                     // Unsupported opcode, no retire
    put({OP_LLB, 4'd10, 8'h5A});
    put({OP_LHB, 4'd10, 8'hA5});       // Shift source 0xA55A
    for (int k = 0; k < 16; k++) begin
      case (k % 3)
        0:       sh = OP_SLL;
        1:       sh = OP_SRA;
        default: sh = OP_ROR;
      endcase
      put({sh, 4'(11 + k % 3), 4'd10, 4'(k)});  // Amounts 0 to 15
    end
    put({OP_PCS, 4'd14, 8'h00});
    put({OP_ADD, 4'd15, 4'd11, 4'd12});
    put({OP_HLT, 12'h000});
    put({OP_ADD, 4'd1, 4'd1, 4'd1});   // Past the halt
    put({OP_XOR, 4'd2, 4'd2, 4'd2});
    put({OP_PCS, 4'd3, 8'h00});
  end

  //////////////////////////////////////////////////
  // Request responder
  //////////////////////////////////////////////////
  initial begin : responder
    int unsigned delay;
    word_t       addr;
    mem_data_valid = 1'b0;
    mem_data_in    = '0;
    @(posedge clk);
    #DRIVE_DLY;
    forever begin
      if (rst_n && mem_en) begin
        addr  = mem_addr;                                      // Request of this cycle
        delay = 1 + ($unsigned($random(seed)) % MAX_LAT);      // 1 to MAX_LAT cycles
        repeat (delay) @(posedge clk);
        #DRIVE_DLY;
        mem_data_valid = 1'b1;
        mem_data_in    = prog[addr[AW:1]];
        @(posedge clk);
        #DRIVE_DLY;
        mem_data_valid = 1'b0;
        mem_data_in    = '0;
      end else begin
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
  end

endmodule

`default_nettype wire
